// ==== compile.f ====
hdl/ipod_pkg.sv
hdl/player_ctrl_if.sv
hdl/player_command_decoder.sv
hdl/flash_word_fetcher.sv
hdl/sample_fifo.sv
hdl/sample_player.sv
hdl/ipod_player_top.sv
sim/flash_model.sv
sim/tb_ipod_player.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ipod_player -f compile.f --Mdir obj_dir -o tb_ipod_player \
  && ./obj_dir/tb_ipod_player | tee /dev/stderr | grep -qx "Test passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== sim/tb_ipod_player.sv ====
`timescale 1ns/1ps

module tb_ipod_player;
  import ipod_pkg::*;

  localparam logic [15:0] FLASH_PATTERN  = 16'hA5A5;
  localparam int          RANDOM_SEED    = 46519;
  localparam int          STROBE_TIMEOUT = 2 * int'(MAX_DIVIDER) + 64;

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  logic [7:0]  ascii_code;
  logic        ascii_valid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_strobe;

  // Source of the next strobed sample
  flash_addr_t exp_addr;
  logic        exp_half;
  logic        exp_rev;

  int check_count;
  int mismatch_count;
  int other_error_count;

  always #10 CLK_50M = ~CLK_50M;

  ipod_player_top uut (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .ascii_code          (ascii_code),
    .ascii_valid         (ascii_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_strobe       (sample_strobe)
  );

  flash_model #(.PATTERN(FLASH_PATTERN), .SEED(RANDOM_SEED)) flash (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  // ====================================================================
  // Expected sample order and checking
  // ====================================================================
  function automatic sample_t expected_sample();
    // Forward plays low half first, backward high half first
    if (exp_half ^ exp_rev)
      return exp_addr[15:0] ^ FLASH_PATTERN;
    return exp_addr[15:0];
  endfunction

  task automatic advance_expected();
    if (exp_half)
    begin
      if (exp_rev)
        exp_addr = (exp_addr == '0) ? LAST_WORD_ADDR : exp_addr - flash_addr_t'(1);
      else
        exp_addr = (exp_addr == LAST_WORD_ADDR) ? '0 : exp_addr + flash_addr_t'(1);
    end
    exp_half = ~exp_half;
  endtask

  task automatic compare_values(input int expected, input int actual, input string what);
    check_count++;
    if (expected != actual)
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s, expected 0x%0h, got 0x%0h", $time, what, expected, actual);
    end
  endtask

  // Returns the cycles since the call, checks the strobed sample
  task automatic await_strobe(output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < STROBE_TIMEOUT)
    begin
      @(posedge CLK_50M);
      cycles++;
      seen = sample_strobe;
    end
    if (!seen)
    begin
      other_error_count++;
      $display("Error at %0t: no sample_strobe within %0d cycles", $time, STROBE_TIMEOUT);
    end
    else
    begin
      compare_values(int'(expected_sample()), int'(audio_sample), "strobed sample");
      advance_expected();
    end
  endtask

  task automatic quiet_for(input int n);
    repeat (n)
    begin
      @(posedge CLK_50M);
      if (sample_strobe)
      begin
        other_error_count++;
        $display("Error at %0t: sample_strobe fired while playback was paused", $time);
      end
    end
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================
  task automatic apply_reset();
    repeat (16) @(posedge CLK_50M);
    rst_n <= 1'b1;
    @(posedge CLK_50M);
  endtask

  task automatic send_ascii(input logic [7:0] code);
    ascii_code  <= code;
    ascii_valid <= 1'b1;
    @(posedge CLK_50M);
    ascii_valid <= 1'b0;
    @(posedge CLK_50M);
  endtask

  task automatic pulse_speed_up();
    speed_up <= 1'b1;
    @(posedge CLK_50M);
    speed_up <= 1'b0;
    @(posedge CLK_50M);
  endtask

  task automatic pulse_speed_reset();
    speed_reset <= 1'b1;
    @(posedge CLK_50M);
    speed_reset <= 1'b0;
    @(posedge CLK_50M);
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic startup_order();
    int cycles;
    repeat (8) await_strobe(cycles);
  endtask

  task automatic speed_steps();
    int cycles;
    await_strobe(cycles);
    compare_values(int'(DEFAULT_DIVIDER), cycles, "default strobe interval");
    pulse_speed_up();
    pulse_speed_up();
    // The running period still uses the old divider
    await_strobe(cycles);
    await_strobe(cycles);
    compare_values(int'(DEFAULT_DIVIDER) - 2 * int'(SPEED_STEP), cycles,
                   "interval after two speed_up pulses");
    repeat (80) pulse_speed_up();
    await_strobe(cycles);
    await_strobe(cycles);
    compare_values(int'(MIN_DIVIDER), cycles, "interval at lower clamp");
    pulse_speed_reset();
    await_strobe(cycles);
    await_strobe(cycles);
    compare_values(int'(DEFAULT_DIVIDER), cycles, "interval after speed_reset");
  endtask

  task automatic pause_and_resume();
    int cycles;
    send_ascii(CMD_PAUSE);
    quiet_for(3 * int'(DEFAULT_DIVIDER));
    send_ascii(CMD_PLAY);
    repeat (6) await_strobe(cycles);
  endtask

  task automatic unknown_code_ignored();
    int cycles;
    // ASCII 'x'
    send_ascii(8'h78);
    await_strobe(cycles);
    await_strobe(cycles);
    compare_values(int'(DEFAULT_DIVIDER), cycles, "interval after unknown code");
    // Past the buffered samples into words fetched after the code
    repeat (10) await_strobe(cycles);
  endtask

  task automatic backward_restart_wrap();
    int cycles;
    send_ascii(CMD_PAUSE);
    quiet_for(4);
    send_ascii(CMD_BACKWARD);
    send_ascii(CMD_RESTART);
    quiet_for(40);
    exp_addr = '0;
    exp_half = 1'b0;
    exp_rev  = 1'b1;
    send_ascii(CMD_PLAY);
    repeat (6) await_strobe(cycles);
  endtask

  task automatic final_report();
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             check_count, mismatch_count, other_error_count);
    if (mismatch_count == 0 && other_error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  initial
  begin
    rst_n             = 1'b0;
    ascii_code        = '0;
    ascii_valid       = 1'b0;
    speed_up          = 1'b0;
    speed_down        = 1'b0;
    speed_reset       = 1'b0;
    exp_addr          = '0;
    exp_half          = 1'b0;
    exp_rev           = 1'b0;
    check_count       = 0;
    mismatch_count    = 0;
    other_error_count = 0;
    apply_reset();
    startup_order();
    speed_steps();
    pause_and_resume();
    unknown_code_ignored();
    backward_restart_wrap();
    final_report();
  end

endmodule

// ==== sim/flash_model.sv ====
`timescale 1ns/1ps

module flash_model #(
  parameter logic [15:0] PATTERN = 16'h0000,
  parameter int          SEED    = 1
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  flash_read,
  input  ipod_pkg::flash_addr_t flash_address,
  output logic                  flash_waitrequest,
  output ipod_pkg::flash_word_t flash_readdata,
  output logic                  flash_readdatavalid
);
  import ipod_pkg::*;

  logic        busy;
  logic [2:0]  delay;
  flash_addr_t read_addr;

  initial
  begin
    void'($urandom(SEED));
  end

  // Low half is the address, high half the address XOR pattern
  function automatic flash_word_t word_at(input flash_addr_t addr);
    return {addr[15:0] ^ PATTERN, addr[15:0]};
  endfunction

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      flash_waitrequest   <= 1'b1;
      flash_readdatavalid <= 1'b0;
      busy                <= 1'b0;
      delay               <= '0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      // Roughly one cycle in three stalls
      flash_waitrequest <= ($urandom_range(2, 0) == 0);
      if (flash_read && !flash_waitrequest && !busy)
      begin
        read_addr <= flash_address;
        delay     <= 3'($urandom_range(4, 1));
        busy      <= 1'b1;
      end
      else if (busy)
      begin
        if (delay == 3'd1)
        begin
          flash_readdata      <= word_at(read_addr);
          flash_readdatavalid <= 1'b1;
          busy                <= 1'b0;
        end
        else
          delay <= delay - 3'd1;
      end
    end
  end

endmodule

// ==== hdl/ipod_player_top.sv ====
`timescale 1ns/1ps

module ipod_player_top (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [7:0]            ascii_code,
  input  logic                  ascii_valid,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_strobe
);
  import ipod_pkg::*;

  player_ctrl_if ctrl_if ();

  logic    push;
  sample_t push_sample;
  logic    almost_full;
  logic    pop;
  sample_t head_sample;
  logic    empty;

  // ======================================================================
  // Command path
  // ======================================================================
  player_command_decoder u_decoder (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .ctrl        (ctrl_if.decoder)
  );

  // ======================================================================
  // Sample path
  // ======================================================================
  flash_word_fetcher u_fetcher (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .ctrl                (ctrl_if.fetcher),
    .almost_full         (almost_full),
    .push                (push),
    .push_sample         (push_sample),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  // Restart empties the buffer too
  sample_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .flush       (ctrl_if.restart),
    .push        (push),
    .push_sample (push_sample),
    .almost_full (almost_full),
    .pop         (pop),
    .pop_sample  (head_sample),
    .empty       (empty)
  );

  sample_player u_player (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .ctrl          (ctrl_if.player),
    .empty         (empty),
    .pop           (pop),
    .head_sample   (head_sample),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

endmodule

// ==== hdl/sample_player.sv ====
`timescale 1ns/1ps

module sample_player (
  input  logic              CLK_50M,
  input  logic              rst_n,
  player_ctrl_if.player     ctrl,
  input  logic              empty,
  output logic              pop,
  input  ipod_pkg::sample_t head_sample,
  output ipod_pkg::sample_t audio_sample,
  output logic              sample_strobe
);
  import ipod_pkg::*;

  divider_t period_cnt;
  // Divider in force for the running period
  divider_t period_div;
  logic     playing;
  logic     period_end;

  assign playing    = !ctrl.pause && !empty;
  assign period_end = period_cnt == divider_t'(period_div - 1'b1);
  assign pop        = playing && period_end;

  // ======================================================================
  // Period counter
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      period_cnt    <= '0;
      period_div    <= DEFAULT_DIVIDER;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= pop;
      // Idle restarts the period with the latest divider
      if (!playing || period_end)
      begin
        period_cnt <= '0;
        period_div <= ctrl.divider;
      end
      else
        period_cnt <= period_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (pop)
      audio_sample <= head_sample;
  end

endmodule

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
  parameter int DEPTH = ipod_pkg::FIFO_DEPTH
) (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              push,
  input  ipod_pkg::sample_t push_sample,
  output logic              almost_full,
  input  logic              pop,
  output ipod_pkg::sample_t pop_sample,
  output logic              empty
);
  import ipod_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sample_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // At most one free slot left
  assign almost_full = count >= CNT_W'(DEPTH - 1);
  assign empty       = count == '0;
  assign pop_sample  = mem[rd_ptr];

  // ======================================================================
  // Pointers and count
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage, flush drops a same-cycle push
  always_ff @(posedge CLK_50M)
  begin
    if (push && !flush)
      mem[wr_ptr] <= push_sample;
  end

  no_push_when_full: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    push && !flush |-> count < CNT_W'(DEPTH));

  no_pop_when_empty: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    pop |-> !empty);

endmodule

// ==== hdl/flash_word_fetcher.sv ====
`timescale 1ns/1ps

module flash_word_fetcher (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  player_ctrl_if.fetcher       ctrl,
  input  logic                 almost_full,
  output logic                 push,
  output ipod_pkg::sample_t    push_sample,
  output logic                 flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                 flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                 flash_readdatavalid
);
  import ipod_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_PUSH_FIRST,
    S_PUSH_SECOND
  } state_t;

  state_t      state;
  flash_addr_t next_addr;
  flash_addr_t step_addr;
  flash_word_t word_q;
  logic        word_rev;
  logic        discard;
  logic        take_low;

  // Forward plays low then high, backward the reverse
  assign take_low    = (state == S_PUSH_FIRST) ^ word_rev;
  assign push        = (state == S_PUSH_FIRST) || (state == S_PUSH_SECOND);
  assign push_sample = take_low ? word_q[SAMPLE_W-1:0] : word_q[2*SAMPLE_W-1:SAMPLE_W];

  // Address after the current word, wrapping at either end
  always_comb
  begin
    if (word_rev)
      step_addr = (next_addr == '0) ? LAST_WORD_ADDR : next_addr - 1'b1;
    else
      step_addr = (next_addr == LAST_WORD_ADDR) ? '0 : next_addr + 1'b1;
  end

  // ======================================================================
  // Read sequencing
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      flash_read <= 1'b0;
      next_addr  <= '0;
      discard    <= 1'b0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (!almost_full && !ctrl.restart)
          begin
            flash_read <= 1'b1;
            state      <= S_REQ;
          end
        S_REQ:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= S_WAIT;
          end
        S_WAIT:
          if (flash_readdatavalid)
          begin
            discard <= 1'b0;
            if (discard || ctrl.restart)
              state <= S_IDLE;
            else
            begin
              next_addr <= step_addr;
              state     <= S_PUSH_FIRST;
            end
          end
        S_PUSH_FIRST:
          state <= ctrl.restart ? S_IDLE : S_PUSH_SECOND;
        default:
          state <= S_IDLE;
      endcase

      // Outstanding read still completes, its data is dropped
      if (ctrl.restart)
      begin
        next_addr <= '0;
        if (state == S_REQ || (state == S_WAIT && !flash_readdatavalid))
          discard <= 1'b1;
      end
    end
  end

  // Address, direction and word are payload
  always_ff @(posedge CLK_50M)
  begin
    if (state == S_IDLE && !almost_full && !ctrl.restart)
    begin
      flash_address <= next_addr;
      word_rev      <= ctrl.reverse;
    end
    if (state == S_WAIT && flash_readdatavalid)
      word_q <= flash_readdata;
  end

  address_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

endmodule

// ==== hdl/player_command_decoder.sv ====
`timescale 1ns/1ps

module player_command_decoder (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [7:0]            ascii_code,
  input  logic                  ascii_valid,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  player_ctrl_if.decoder        ctrl
);
  import ipod_pkg::*;

  // Clamp checks done before stepping to avoid wrap
  logic at_low_clamp;
  logic at_high_clamp;

  assign at_low_clamp  = ctrl.divider <= MIN_DIVIDER + SPEED_STEP;
  assign at_high_clamp = ctrl.divider >= MAX_DIVIDER - SPEED_STEP;

  // ======================================================================
  // Command state
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      ctrl.pause   <= 1'b0;
      ctrl.reverse <= 1'b0;
      ctrl.restart <= 1'b0;
      ctrl.divider <= DEFAULT_DIVIDER;
    end
    else
    begin
      ctrl.restart <= 1'b0;

      // Unknown codes fall through untouched
      if (ascii_valid)
      begin
        case (ascii_code)
          CMD_PLAY:     ctrl.pause   <= 1'b0;
          CMD_PAUSE:    ctrl.pause   <= 1'b1;
          CMD_FORWARD:  ctrl.reverse <= 1'b0;
          CMD_BACKWARD: ctrl.reverse <= 1'b1;
          CMD_RESTART:  ctrl.restart <= 1'b1;
          default:      ;
        endcase
      end

      // Speed reset wins, then up, then down
      if (speed_reset)
        ctrl.divider <= DEFAULT_DIVIDER;
      else if (speed_up)
        ctrl.divider <= at_low_clamp ? MIN_DIVIDER : ctrl.divider - SPEED_STEP;
      else if (speed_down)
        ctrl.divider <= at_high_clamp ? MAX_DIVIDER : ctrl.divider + SPEED_STEP;
    end
  end

  divider_in_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ctrl.divider >= MIN_DIVIDER && ctrl.divider <= MAX_DIVIDER);

endmodule

// ==== hdl/player_ctrl_if.sv ====
`timescale 1ns/1ps

interface player_ctrl_if;
  import ipod_pkg::*;

  // Levels
  logic     pause;
  logic     reverse;
  divider_t divider;
  // One-cycle pulse
  logic     restart;

  modport decoder (
    output pause,
    output reverse,
    output restart,
    output divider
  );

  modport fetcher (input reverse, input restart);

  modport player (input pause, input divider);

endinterface

// ==== hdl/ipod_pkg.sv ====
package ipod_pkg;

  // ======================================================================
  // Sample and flash widths
  // ======================================================================
  localparam int SAMPLE_W = 16;
  typedef logic [SAMPLE_W-1:0] sample_t;

  localparam int FLASH_ADDR_W = 23;
  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

  // Each flash word packs two samples
  typedef logic [2*SAMPLE_W-1:0] flash_word_t;

  // Song occupies words 0 through this address
  localparam flash_addr_t LAST_WORD_ADDR = 23'h7FFFF;

  // ======================================================================
  // Sample rate divider
  // ======================================================================
  localparam int DIVIDER_W = 16;
  typedef logic [DIVIDER_W-1:0] divider_t;

  // About 44 kHz from the 50 MHz clock
  localparam divider_t DEFAULT_DIVIDER = 16'd1136;
  localparam divider_t SPEED_STEP      = 16'd16;
  localparam divider_t MIN_DIVIDER     = 16'd64;
  localparam divider_t MAX_DIVIDER     = 16'd4096;

  // ======================================================================
  // Buffering and keyboard commands
  // ======================================================================
  localparam int FIFO_DEPTH = 8;

  // ASCII 'E'
  localparam logic [7:0] CMD_PLAY     = 8'h45;
  // ASCII 'D'
  localparam logic [7:0] CMD_PAUSE    = 8'h44;
  // ASCII 'F'
  localparam logic [7:0] CMD_FORWARD  = 8'h46;
  // ASCII 'B'
  localparam logic [7:0] CMD_BACKWARD = 8'h42;
  // ASCII 'R'
  localparam logic [7:0] CMD_RESTART  = 8'h52;

endpackage
